//--- source/i2s_pkg.sv
// i2s_pkg: clock-ratio and lane constants, tx frame, lane strobe and rx word structs

package i2s_pkg;

  // lanes sharing one bck and one lrck
  localparam int NUM_LANES = 4;
  localparam int LANE_W    = 2;

  // clocks per bck period, bits per lrck frame
  localparam int BCK_DIV    = 25;
  localparam int FRAME_BITS = 64;
  localparam int HALF_BITS  = FRAME_BITS / 2;

  // bck rises at CNT_RISE, falls at CNT_FULL
  // shift register loads one clock before the fall
  localparam int CNT_FULL = BCK_DIV - 1;
  localparam int CNT_RISE = BCK_DIV / 2;
  localparam int CNT_LOAD = BCK_DIV - 2;

  localparam int CLK_CNT_W = $clog2(BCK_DIV);
  localparam int BIT_CNT_W = $clog2(FRAME_BITS);

  // tx sample width, rx capture one bit wider for rounding
  localparam int TX_BITS = 16;
  localparam int RX_BITS = TX_BITS + 1;

  // shift counter must reach RX_BITS
  localparam int SHIFT_CNT_W = $clog2(RX_BITS + 1);

  // one lane's stereo pair, left sent first
  typedef struct packed {
    logic [TX_BITS-1:0] left;
    logic [TX_BITS-1:0] right;
  } tx_frame_t;

  // single-cycle timing pulses, same for every lane
  typedef struct packed {
    logic load_left;
    logic load_right;
    logic shift;
    logic bit_out;
    logic rx_take;
  } lane_strobe_t;

  // collector output word
  typedef struct packed {
    logic [LANE_W-1:0]  lane;
    logic [TX_BITS-1:0] data;
  } rx_word_t;

endpackage

//--- source/i2s_frame_timer.sv
// i2s_frame_timer: bit and word counters, bck and lrck, lane strobes and tx request
`timescale 1ns/1ps

module i2s_frame_timer (
  input  logic                  clk,
  input  logic                  arst_n,
  output logic                  bck,
  output logic                  lrck,
  output i2s_pkg::lane_strobe_t strobe,
  output logic                  tx_req
);

  import i2s_pkg::*;

  logic [CLK_CNT_W-1:0] clk_cnt;
  logic [BIT_CNT_W-1:0] bit_cnt;
  logic                 clk_full;
  logic                 clk_rise;
  logic                 clk_load;
  logic                 bit_last;
  logic                 bit_half;
  logic                 bit_zero;
  logic                 in_comm;
  logic                 comm_d;

  // clock count decodes
  assign clk_full = (clk_cnt == CLK_CNT_W'(CNT_FULL));
  assign clk_rise = (clk_cnt == CLK_CNT_W'(CNT_RISE));
  assign clk_load = (clk_cnt == CLK_CNT_W'(CNT_LOAD));

  // bit count decodes
  assign bit_last = (bit_cnt == BIT_CNT_W'(FRAME_BITS - 1));
  assign bit_half = (bit_cnt == BIT_CNT_W'(HALF_BITS - 1));
  assign bit_zero = (bit_cnt == '0);

  // communication windows, RX_BITS long at the start of each half
  assign in_comm = (bit_cnt < BIT_CNT_W'(RX_BITS)) ||
                   ((bit_cnt >= BIT_CNT_W'(HALF_BITS)) &&
                    (bit_cnt < BIT_CNT_W'(HALF_BITS + RX_BITS)));

  // clock counter, one bck period
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      clk_cnt <= '0;
    end else if (clk_full) begin
      clk_cnt <= '0;
    end else begin
      clk_cnt <= clk_cnt + 1'b1;
    end
  end

  // bit counter, one lrck frame
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      bit_cnt <= '0;
    end else if (clk_full) begin
      if (bit_last) begin
        bit_cnt <= '0;
      end else begin
        bit_cnt <= bit_cnt + 1'b1;
      end
    end
  end

  // bck low from the fall point to mid bit
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      bck <= 1'b0;
    end else if (clk_full) begin
      bck <= 1'b0;
    end else if (clk_rise) begin
      bck <= 1'b1;
    end
  end

  // lrck toggles together with a bck fall
  // low = left half, high = right half
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      lrck <= 1'b0;
    end else if (clk_full && bit_last) begin
      lrck <= 1'b0;
    end else if (clk_full && bit_half) begin
      lrck <= 1'b1;
    end
  end

  // window delayed one bit so shifting trails the mosi bits
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      comm_d <= 1'b0;
    end else if (clk_full) begin
      comm_d <= in_comm;
    end
  end

  // lane strobes, decoded straight from the counters
  always_comb begin
    strobe.load_left  = bit_zero && clk_load;
    strobe.load_right = bit_half && clk_load;
    strobe.shift      = comm_d && clk_rise;
    strobe.bit_out    = clk_full;
    // left slot complete at mid frame
    strobe.rx_take    = bit_half && clk_rise;
  end

  // next frame's data wanted once right has been loaded
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      tx_req <= 1'b0;
    end else begin
      tx_req <= strobe.load_right;
    end
  end

endmodule

//--- source/i2s_lane.sv
// i2s_lane: one lane's shift register, mosi driver, miso synchronizer and rx rounding
`timescale 1ns/1ps

module i2s_lane (
  input  logic                        clk,
  input  logic                        arst_n,
  input  i2s_pkg::lane_strobe_t       strobe,
  input  i2s_pkg::tx_frame_t          tx_frame,
  input  logic                        miso,
  output logic                        mosi,
  output logic [i2s_pkg::TX_BITS-1:0] rx_sample,
  output logic                        rx_valid
);

  import i2s_pkg::*;

  logic                   miso_d;
  logic [RX_BITS-1:0]     sfr;
  logic [SHIFT_CNT_W-1:0] shift_cnt;
  logic                   active;
  logic                   lead;
  logic                   loading;
  logic [TX_BITS-1:0]     rounded;

  assign loading = strobe.load_left || strobe.load_right;

  // miso sync, one flop
  always_ff @(posedge clk) begin
    miso_d <= miso;
  end

  // tx sample plus one pad bit, rx bits enter at the bottom
  always_ff @(posedge clk) begin
    if (strobe.load_left) begin
      sfr <= {tx_frame.left, 1'b0};
    end else if (strobe.load_right) begin
      sfr <= {tx_frame.right, 1'b0};
    end else if (strobe.shift) begin
      sfr <= {sfr[RX_BITS-2:0], miso_d};
    end
  end

  // active from a load to the seventeenth shift
  // right load comes one bit early, lead masks that bit
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      shift_cnt <= '0;
      active    <= 1'b0;
      lead      <= 1'b0;
    end else if (loading) begin
      shift_cnt <= '0;
      active    <= 1'b1;
      lead      <= strobe.load_right;
    end else begin
      if (strobe.shift && active) begin
        shift_cnt <= shift_cnt + 1'b1;
        if (shift_cnt == SHIFT_CNT_W'(RX_BITS - 1)) begin
          active <= 1'b0;
        end
      end
      if (strobe.bit_out) begin
        lead <= 1'b0;
      end
    end
  end

  // mosi updates on bck fall only, low outside the window
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mosi <= 1'b0;
    end else if (strobe.bit_out) begin
      mosi <= (active && !lead) ? sfr[RX_BITS-1] : 1'b0;
    end
  end

  // negative words round up by the dropped lsb
  assign rounded = sfr[RX_BITS-1] ? sfr[RX_BITS-1:1] + TX_BITS'(sfr[0])
                                  : sfr[RX_BITS-1:1];

  always_ff @(posedge clk) begin
    if (strobe.rx_take) begin
      rx_sample <= rounded;
    end
  end

  // valid alongside the registered sample
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= strobe.rx_take;
    end
  end

endmodule

//--- source/i2s_rx_collector.sv
// i2s_rx_collector: latch every lane's rx sample and emit them one lane per cycle
`timescale 1ns/1ps

module i2s_rx_collector (
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic [i2s_pkg::TX_BITS-1:0] lane_sample [i2s_pkg::NUM_LANES],
  input  logic                        lane_valid,
  output i2s_pkg::rx_word_t           rx_out,
  output logic                        rx_out_valid
);

  import i2s_pkg::*;

  logic [TX_BITS-1:0] held [NUM_LANES];
  logic [LANE_W-1:0]  idx;
  logic               busy;
  logic               last;

  assign last = (idx == LANE_W'(NUM_LANES - 1));

  // snapshot of all lanes, taken in one cycle
  always_ff @(posedge clk) begin
    if (lane_valid) begin
      for (int i = 0; i < NUM_LANES; i++) begin
        held[i] <= lane_sample[i];
      end
    end
  end

  // drain counter
  // new capture restarts at lane 0
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      busy <= 1'b0;
      idx  <= '0;
    end else if (lane_valid) begin
      busy <= 1'b1;
      idx  <= '0;
    end else if (busy) begin
      if (last) begin
        busy <= 1'b0;
        idx  <= '0;
      end else begin
        idx <= idx + 1'b1;
      end
    end
  end

  // output mux, valid while draining
  always_comb begin
    rx_out.lane  = idx;
    rx_out.data  = held[idx];
    rx_out_valid = busy;
  end

endmodule

//--- source/i2s_multi_lane.sv
// i2s_multi_lane: top level with frame timer, lane array and rx collector
`timescale 1ns/1ps

module i2s_multi_lane (
  input  logic                          clk,
  input  logic                          arst_n,
  input  i2s_pkg::tx_frame_t            tx_data [i2s_pkg::NUM_LANES],
  output logic                          tx_req,
  output logic                          bck,
  output logic                          lrck,
  output logic [i2s_pkg::NUM_LANES-1:0] mosi,
  input  logic [i2s_pkg::NUM_LANES-1:0] miso,
  output i2s_pkg::rx_word_t             rx_out,
  output logic                          rx_out_valid
);

  import i2s_pkg::*;

  lane_strobe_t         strobe;
  logic [TX_BITS-1:0]   lane_sample [NUM_LANES];
  logic [NUM_LANES-1:0] lane_valid;

  // shared timing for every lane
  i2s_frame_timer u_timer (
    .clk    (clk),
    .arst_n (arst_n),
    .bck    (bck),
    .lrck   (lrck),
    .strobe (strobe),
    .tx_req (tx_req)
  );

  // lanes run in lockstep off the same strobes
  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    i2s_lane u_lane (
      .clk       (clk),
      .arst_n    (arst_n),
      .strobe    (strobe),
      .tx_frame  (tx_data[i]),
      .miso      (miso[i]),
      .mosi      (mosi[i]),
      .rx_sample (lane_sample[i]),
      .rx_valid  (lane_valid[i])
    );
  end

  // lane 0 valid stands for all lanes
  i2s_rx_collector u_collector (
    .clk          (clk),
    .arst_n       (arst_n),
    .lane_sample  (lane_sample),
    .lane_valid   (lane_valid[0]),
    .rx_out       (rx_out),
    .rx_out_valid (rx_out_valid)
  );

endmodule

//--- bench/tb_clock.sv
// tb_clock: testbench clock, 8 ns period, and active-low reset held for 3 cycles
`timescale 1ns/1ps

module tb_clock (
  output logic clk,
  output logic arst_n
);

  // free running clock
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // falling reset edge at 1 ns, released on a falling clock edge
  initial begin
    arst_n = 1'b1;
    #1;
    arst_n = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
  end

endmodule

//--- bench/codec_model.sv
// codec_model: codec stand-in that sends 24-bit left words on miso and captures mosi frames
`timescale 1ns/1ps

module codec_model #(
  parameter int DEPTH = 1
) (
  input  logic               bck,
  input  logic               lrck,
  input  logic               mosi,
  output logic               miso = 1'b0,
  input  logic [23:0]        words [DEPTH],
  output i2s_pkg::tx_frame_t cap_frame = '0,
  output int                 cap_count = 0
);

  import i2s_pkg::*;

  // bit slot within the current half frame, counted on bck rise
  int                 slot = 31;
  int                 ptr = 0;
  logic               lr_cur = 1'b1;
  logic [23:0]        cur_word = '0;
  logic [TX_BITS-1:0] sh = '0;
  logic [TX_BITS-1:0] left_cap = '0;

  // mosi capture, slots 1 to 16 of each half
  always @(posedge bck) begin
    // new half frame when lrck differs from the previous bit
    if (lrck != lr_cur) begin
      slot = 0;
    end else begin
      slot = slot + 1;
    end
    lr_cur = lrck;
    if (slot >= 1 && slot <= TX_BITS) begin
      sh = {sh[TX_BITS-2:0], mosi};
      if (slot == TX_BITS) begin
        if (!lrck) begin
          left_cap = sh;
        end else begin
          cap_frame = {left_cap, sh};
          cap_count = cap_count + 1;
        end
      end
    end
  end

  // miso drive, MSB one bit after the lrck fall
  always @(negedge bck) begin
    if (!lr_cur && slot == 0) begin
      cur_word = (ptr < DEPTH) ? words[ptr] : 24'h000000;
      ptr = ptr + 1;
    end
    // right slot and tail of left stay low
    if (!lr_cur && slot < 24) begin
      miso <= cur_word[23 - slot];
    end else begin
      miso <= 1'b0;
    end
  end

endmodule

//--- bench/i2s_timer_properties.sv
// i2s_timer_properties: bck, lrck, tx_req and strobe assertions bound to the frame timer
`timescale 1ns/1ps

module i2s_timer_properties (
  input logic                  clk,
  input logic                  arst_n,
  input logic                  bck,
  input logic                  lrck,
  input logic                  tx_req,
  input i2s_pkg::lane_strobe_t strobe
);

  import i2s_pkg::*;

  logic [5:0] age;
  logic       warm;

  // enough history for a full bck period of $past
  assign warm = (age > 6'(BCK_DIV));

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      age <= '0;
    end else if (!warm) begin
      age <= age + 1'b1;
    end
  end

  a_bck_period: assert property (@(posedge clk) disable iff (!arst_n)
    warm |-> (bck == $past(bck, BCK_DIV)))
    else $error("bck does not repeat every BCK_DIV clocks");

  // lrck edges line up with bck falls
  a_lrck_edge: assert property (@(posedge clk) disable iff (!arst_n)
    $changed(lrck) |-> $fell(bck))
    else $error("lrck changed away from a bck fall");

  a_req_pulse: assert property (@(posedge clk) disable iff (!arst_n)
    tx_req |=> !tx_req)
    else $error("tx_req high for more than one cycle");

  a_strobe_excl: assert property (@(posedge clk) disable iff (!arst_n)
    $onehot0({strobe.load_left, strobe.load_right, strobe.shift}))
    else $error("load and shift strobes overlap");

endmodule

bind i2s_frame_timer i2s_timer_properties u_props (.*);

//--- bench/tb_i2s_multi_lane.sv
// tb_i2s_multi_lane: testbench top, stimulus, rounding reference, compare tasks, checker, watchdog
`timescale 1ns/1ps

module tb_i2s_multi_lane;

  import i2s_pkg::*;

  localparam int     NUM_FRAMES = 12;
  localparam int     FRAME_CYC  = FRAME_BITS * BCK_DIV;
  // tx_req one cycle after the right load at bit 31
  localparam int     FIRST_REQ  = (FRAME_BITS / 2) * BCK_DIV - 1;
  localparam longint TIMEOUT_NS = longint'(NUM_FRAMES + 3) * FRAME_CYC * 8;
  localparam logic [23:0] EDGES [6] = '{24'h000000, 24'hffffff, 24'h800000,
                                        24'h7fffff, 24'hff0080, 24'h00ff80};

  logic                 clk;
  logic                 arst_n;
  tx_frame_t            tx_data [NUM_LANES];
  logic                 tx_req;
  logic                 bck;
  logic                 lrck;
  logic [NUM_LANES-1:0] mosi;
  logic [NUM_LANES-1:0] miso;
  rx_word_t             rx_out;
  logic                 rx_out_valid;

  // codec words per lane and frame, tx data per frame and lane
  logic [23:0] rx_words [NUM_LANES][NUM_FRAMES];
  tx_frame_t   tx_hist [NUM_FRAMES+1][NUM_LANES];
  tx_frame_t   cap_frame [NUM_LANES];
  int          cap_count [NUM_LANES];
  int          tx_checked [NUM_LANES];
  tx_frame_t   next_frame;
  rx_word_t    exp_word;
  int          wr_frame = 1;
  int          cyc = 0;
  int          req_count = 0;
  int          rx_frame = 0;
  int          run_idx = 0;
  int          slot_now = 0;
  logic        done = 1'b0;

  tb_clock u_clock (
    .clk    (clk),
    .arst_n (arst_n)
  );

  i2s_multi_lane u_dut (
    .clk          (clk),
    .arst_n       (arst_n),
    .tx_data      (tx_data),
    .tx_req       (tx_req),
    .bck          (bck),
    .lrck         (lrck),
    .mosi         (mosi),
    .miso         (miso),
    .rx_out       (rx_out),
    .rx_out_valid (rx_out_valid)
  );

  for (genvar i = 0; i < NUM_LANES; i++) begin : g_codec
    codec_model #(.DEPTH(NUM_FRAMES)) u_codec (
      .bck       (bck),
      .lrck      (lrck),
      .mosi      (mosi[i]),
      .miso      (miso[i]),
      .words     (rx_words[i]),
      .cap_frame (cap_frame[i]),
      .cap_count (cap_count[i])
    );
  end

  // top 16 bits of the word, plus the seventeenth bit when the word is negative
  function automatic logic [TX_BITS-1:0] round_ref(input logic [23:0] word);
    logic [TX_BITS-1:0] top;
    top = word[23 -: TX_BITS];
    if (word[23] && word[24 - RX_BITS]) begin
      top = top + 1'b1;
    end
    return top;
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic compare_rx(input rx_word_t got, input rx_word_t exp);
    if (got !== exp) begin
      fail_run($sformatf("CHECK FAILED at %0t: rx_out got %h expected %h", $time, got, exp));
    end
  endtask

  task automatic compare_tx(input int lane, input tx_frame_t got, input tx_frame_t exp);
    if (got !== exp) begin
      fail_run($sformatf("CHECK FAILED at %0t: mosi[%0d] got %h expected %h",
                         $time, lane, got, exp));
    end
  endtask

  task automatic expect_low(input string name, input logic got);
    if (got !== 1'b0) begin
      fail_run($sformatf("CHECK FAILED at %0t: %s got %b expected 0", $time, name, got));
    end
  endtask

  task automatic match_cycle(input string name, input int got, input int exp);
    if (got != exp) begin
      fail_run($sformatf("CHECK FAILED at %0t: %s cycle got %0d expected %0d",
                         $time, name, got, exp));
    end
  endtask

  // clocks since reset release
  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cyc <= 0;
    end else begin
      cyc <= cyc + 1;
    end
  end

  // fresh tx data in the cycle after tx_req, kept for the next frame
  always @(posedge clk) begin
    if (arst_n && tx_req) begin
      for (int l = 0; l < NUM_LANES; l++) begin
        next_frame = tx_frame_t'($urandom);
        tx_data[l] <= next_frame;
        if (wr_frame <= NUM_FRAMES) begin
          tx_hist[wr_frame][l] = next_frame;
        end
      end
      wr_frame = wr_frame + 1;
    end
  end

  // checker samples away from the rising edge
  always @(negedge clk) begin
    if (arst_n) begin
      // one tx_req per frame
      if (tx_req) begin
        match_cycle("tx_req", cyc, FIRST_REQ + req_count * FRAME_CYC);
        req_count++;
      end
      // mosi low in slot 0 and after slot 16 of each half
      slot_now = (cyc / BCK_DIV) % HALF_BITS;
      if (slot_now == 0 || slot_now > TX_BITS) begin
        expect_low("mosi idle", |mosi);
      end
      // rx burst of NUM_LANES words, lanes in order
      if (rx_out_valid) begin
        if (run_idx == NUM_LANES) begin
          fail_run("rx_out_valid stayed high past the last lane");
        end
        exp_word.lane = LANE_W'(run_idx);
        exp_word.data = (rx_frame < NUM_FRAMES) ? round_ref(rx_words[run_idx][rx_frame]) : '0;
        compare_rx(rx_out, exp_word);
        run_idx++;
      end else if (run_idx != 0) begin
        if (run_idx != NUM_LANES) begin
          fail_run($sformatf("rx burst ended after %0d lanes", run_idx));
        end
        rx_frame++;
        run_idx = 0;
      end
      // mosi frames seen by the codecs
      for (int l = 0; l < NUM_LANES; l++) begin
        if (cap_count[l] > tx_checked[l]) begin
          if (tx_checked[l] <= NUM_FRAMES) begin
            compare_tx(l, cap_frame[l], tx_hist[tx_checked[l]][l]);
          end
          tx_checked[l]++;
        end
      end
      done = (rx_frame >= NUM_FRAMES);
      for (int l = 0; l < NUM_LANES; l++) begin
        if (tx_checked[l] < NUM_FRAMES) begin
          done = 1'b0;
        end
      end
    end
  end

  initial begin
    void'($urandom(32'h13de));
    // edge words first, rotated per lane, then random
    for (int l = 0; l < NUM_LANES; l++) begin
      tx_checked[l] = 0;
      tx_data[l] = tx_frame_t'($urandom);
      tx_hist[0][l] = tx_data[l];
      for (int f = 0; f < NUM_FRAMES; f++) begin
        rx_words[l][f] = (f < 6) ? EDGES[(f + l) % 6] : 24'($urandom);
      end
    end
    // idle levels in reset and just after
    @(negedge clk);
    expect_low("bck", bck);
    expect_low("lrck", lrck);
    expect_low("tx_req", tx_req);
    expect_low("mosi", |mosi);
    expect_low("rx_out_valid", rx_out_valid);
    @(posedge arst_n);
    @(negedge clk);
    expect_low("bck", bck);
    expect_low("lrck", lrck);
    expect_low("tx_req", tx_req);
    expect_low("mosi", |mosi);
    wait (done);
    repeat (4) @(negedge clk);
    if (rx_frame >= NUM_FRAMES && req_count >= NUM_FRAMES) begin
      $display("TEST OK");
      $finish;
    end else begin
      fail_run("run ended before every frame was checked");
    end
  end

  // watchdog fires a few frames beyond the test length
  initial begin
    #(TIMEOUT_NS);
    fail_run($sformatf("watchdog expired after %0d ns", TIMEOUT_NS));
  end

endmodule

//--- src.f
source/i2s_pkg.sv
source/i2s_frame_timer.sv
source/i2s_lane.sv
source/i2s_rx_collector.sv
source/i2s_multi_lane.sv
bench/tb_clock.sv
bench/codec_model.sv
bench/i2s_timer_properties.sv
bench/tb_i2s_multi_lane.sv

//--- Makefile
# Verilator build and run of the I2S multi-lane testbench
TOP := tb_i2s_multi_lane

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f src.f -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP) 2>&1); echo "$$out"; echo "$$out" | grep -q '^TEST OK$$'

clean:
	rm -rf obj_dir
